// ==== common/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;  // Byte address
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;  // One enable per byte lane

  // Core side, request/grant/valid
  typedef struct packed {
    logic  req;
    logic  we;
    strb_t strb;
    addr_t addr;
    data_t wdata;
  } core_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;   // One cycle per accepted request
    logic  err;      // Only meaningful with rvalid
    data_t rdata;
  } core_rsp_t;

  // Classic Wishbone side
  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    strb_t strb;
    addr_t addr;
    data_t wdata;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    data_t rdata;
  } wb_rsp_t;

endpackage

`default_nettype wire

// ==== common/ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

  localparam int TMO_CNT_W = 8;

  // Per-port bridge sequence
  typedef enum logic [1:0] {
    ST_IDLE,  // Grant offered
    ST_BUS,   // Bus cycle open
    ST_RESP   // Response presented to the core
  } bridge_state_e;

  typedef logic [TMO_CNT_W-1:0] tmo_cnt_t;  // Covers limits up to 255

endpackage

`default_nettype wire

// ==== hw/bridge/bridge_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module bridge_fsm (
  input  logic clk_core,
  input  logic rst_n_i,
  input  logic req_i,
  input  logic ack_i,
  input  logic expired_i,
  output logic gnt_o,
  output logic bus_active_o,
  output logic load_o,
  output logic err_o,
  output logic resp_o
);

  import ctrl_pkg::*;

  bridge_state_e state_q;
  bridge_state_e state_d;

  always_ff @(posedge clk_core) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Ack takes priority when it lands on the expiry edge
  always_comb begin
    state_d = state_q;
    load_o  = 1'b0;
    err_o   = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (req_i) begin
          state_d = ST_BUS;  // Accept edge
        end
      end
      ST_BUS: begin
        if (ack_i) begin
          load_o  = 1'b1;
          state_d = ST_RESP;
        end else if (expired_i) begin
          load_o  = 1'b1;
          err_o   = 1'b1;    // Silent slave
          state_d = ST_RESP;
        end
      end
      ST_RESP: begin
        state_d = ST_IDLE;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  assign gnt_o        = (state_q == ST_IDLE);
  assign bus_active_o = (state_q == ST_BUS);   // Drives cyc and stb
  assign resp_o       = (state_q == ST_RESP);

endmodule

`default_nettype wire

// ==== hw/bridge/ack_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module ack_timer #(
  parameter int unsigned TIMEOUT_CYCLES = 16
) (
  input  logic clk_core,
  input  logic rst_n_i,
  input  logic run_i,
  output logic expired_o
);

  import ctrl_pkg::*;

  localparam tmo_cnt_t LIMIT = tmo_cnt_t'(TIMEOUT_CYCLES);

  tmo_cnt_t cnt_q;
  tmo_cnt_t cnt_next;

  assign cnt_next = cnt_q + tmo_cnt_t'(1);

  // Counts edges with the bus cycle open
  always_ff @(posedge clk_core) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (!run_i) begin
      cnt_q <= '0;             // Restart for every bus cycle
    end else if (cnt_q != LIMIT) begin
      cnt_q <= cnt_next;
    end
  end

  // High in the cycle whose closing edge brings the count to the limit
  assign expired_o = run_i && (cnt_next == LIMIT);

endmodule

`default_nettype wire

// ==== hw/bridge/rsp_register.sv ====
`timescale 1ns/1ns
`default_nettype none

module rsp_register (
  input  logic           clk_core,
  input  logic           rst_n_i,
  input  logic           load_i,
  input  logic           err_i,
  input  logic           resp_i,
  input  bus_pkg::data_t rdata_i,
  output logic           rvalid_o,
  output logic           err_o,
  output bus_pkg::data_t rdata_o
);

  import bus_pkg::*;

  data_t rdata_q;
  logic  err_q;

  // Read data path, loaded once per transfer
  always_ff @(posedge clk_core) begin
    if (load_i) begin
      if (err_i) begin
        rdata_q <= '0;     // No data on a timeout
      end else begin
        rdata_q <= rdata_i;
      end
    end
  end

  always_ff @(posedge clk_core) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else if (load_i) begin
      err_q <= err_i;
    end
  end

  // Response lasts as long as the FSM sits in its response state
  assign rvalid_o = resp_i;
  assign err_o    = resp_i & err_q;
  assign rdata_o  = rdata_q;

endmodule

`default_nettype wire

// ==== hw/bridge/bus_bridge.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_bridge #(
  parameter int unsigned TIMEOUT_CYCLES = 16
) (
  input  logic               clk_core,
  input  logic               rst_n_i,
  input  bus_pkg::core_req_t core_req_i,
  input  bus_pkg::wb_rsp_t   wb_rsp_i,
  output bus_pkg::core_rsp_t core_rsp_o,
  output bus_pkg::wb_req_t   wb_req_o
);

  import bus_pkg::*;

  logic  gnt;
  logic  bus_active;
  logic  load;
  logic  load_err;
  logic  resp;
  logic  expired;
  logic  accept;

  logic  we_q;
  strb_t strb_q;
  addr_t addr_q;
  data_t wdata_q;

  logic  rvalid;
  logic  rsp_err;
  data_t rsp_rdata;

  assign accept = core_req_i.req & gnt;

  // Accepted request, held for the whole bus cycle
  always_ff @(posedge clk_core) begin
    if (accept) begin
      we_q    <= core_req_i.we;
      strb_q  <= core_req_i.strb;
      addr_q  <= core_req_i.addr;
      wdata_q <= core_req_i.wdata;
    end
  end

  bridge_fsm u_fsm (
    .clk_core     (clk_core),
    .rst_n_i      (rst_n_i),
    .req_i        (core_req_i.req),
    .ack_i        (wb_rsp_i.ack),
    .expired_i    (expired),
    .gnt_o        (gnt),
    .bus_active_o (bus_active),
    .load_o       (load),
    .err_o        (load_err),
    .resp_o       (resp)
  );

  ack_timer #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) u_timer (
    .clk_core  (clk_core),
    .rst_n_i   (rst_n_i),
    .run_i     (bus_active),
    .expired_o (expired)
  );

  rsp_register u_rsp (
    .clk_core (clk_core),
    .rst_n_i  (rst_n_i),
    .load_i   (load),
    .err_i    (load_err),
    .resp_i   (resp),
    .rdata_i  (wb_rsp_i.rdata),
    .rvalid_o (rvalid),
    .err_o    (rsp_err),
    .rdata_o  (rsp_rdata)
  );

  assign wb_req_o.cyc   = bus_active;
  assign wb_req_o.stb   = bus_active;  // Single beat, strobe follows cycle
  assign wb_req_o.we    = we_q;
  assign wb_req_o.strb  = strb_q;
  assign wb_req_o.addr  = addr_q;
  assign wb_req_o.wdata = wdata_q;

  assign core_rsp_o.gnt    = gnt;
  assign core_rsp_o.rvalid = rvalid;
  assign core_rsp_o.err    = rsp_err;
  assign core_rsp_o.rdata  = rsp_rdata;

endmodule

`default_nettype wire

// ==== hw/core_bus_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module core_bus_top #(
  parameter int unsigned TIMEOUT_CYCLES = 16  // Legal range 2 to 255
) (
  input  logic               clk_core,
  input  logic               rst_n_i,

  // Instruction port
  input  bus_pkg::core_req_t instr_req_i,
  output bus_pkg::core_rsp_t instr_rsp_o,
  output bus_pkg::wb_req_t   instr_wb_req_o,
  input  bus_pkg::wb_rsp_t   instr_wb_rsp_i,

  // Data port
  input  bus_pkg::core_req_t data_req_i,
  output bus_pkg::core_rsp_t data_rsp_o,
  output bus_pkg::wb_req_t   data_wb_req_o,
  input  bus_pkg::wb_rsp_t   data_wb_rsp_i
);

  // Fetch side
  bus_bridge #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) u_instr_bridge (
    .clk_core   (clk_core),
    .rst_n_i    (rst_n_i),
    .core_req_i (instr_req_i),
    .wb_rsp_i   (instr_wb_rsp_i),
    .core_rsp_o (instr_rsp_o),
    .wb_req_o   (instr_wb_req_o)
  );

  // Load/store side, fully independent of fetch
  bus_bridge #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) u_data_bridge (
    .clk_core   (clk_core),
    .rst_n_i    (rst_n_i),
    .core_req_i (data_req_i),
    .wb_rsp_i   (data_wb_rsp_i),
    .core_rsp_o (data_rsp_o),
    .wb_req_o   (data_wb_req_o)
  );

endmodule

`default_nettype wire

// ==== bench/bus_bridge_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_bridge_assertions (
  input logic               clk_core,
  input logic               rst_n_i,
  input bus_pkg::core_rsp_t core_rsp_i,
  input bus_pkg::wb_req_t   wb_req_i
);

  // Grant only offered with the bus idle
  gnt_excludes_cyc: assert property (@(posedge clk_core) disable iff (!rst_n_i)
    !(core_rsp_i.gnt && wb_req_i.cyc))
    else $error("gnt high while cyc is high");

  rvalid_single: assert property (@(posedge clk_core) disable iff (!rst_n_i)
    core_rsp_i.rvalid |=> !core_rsp_i.rvalid)
    else $error("rvalid longer than one cycle");

  // Request fields frozen for the whole cycle
  req_stable: assert property (@(posedge clk_core) disable iff (!rst_n_i)
    wb_req_i.cyc |=> (!wb_req_i.cyc ||
      $stable({wb_req_i.we, wb_req_i.strb, wb_req_i.addr, wb_req_i.wdata})))
    else $error("bus request changed while cyc is high");

  stb_follows_cyc: assert property (@(posedge clk_core) disable iff (!rst_n_i)
    wb_req_i.stb == wb_req_i.cyc)
    else $error("stb differs from cyc");

endmodule

`default_nettype wire

// ==== bench/tb_core_bus.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_core_bus;
  import bus_pkg::*;

  localparam int TIMEOUT_CYCLES = 16;
  localparam int CLK_PERIOD     = 4;
  localparam int TXN_PER_PORT   = 150;
  localparam int TXN_TOTAL      = 2 * TXN_PER_PORT;
  localparam int NEVER          = 255;                 // Slave stays silent
  localparam int WAIT_LIMIT     = TIMEOUT_CYCLES + 8;

  logic      clk_core = 1'b0;
  logic      rst_n;
  core_req_t port_req    [2];                          // Index 0 is instr and 1 is data
  core_rsp_t port_rsp    [2];
  wb_req_t   port_wb_req [2];
  wb_rsp_t   port_wb_rsp [2];
  data_t     slave_mem   [256];
  data_t     model_mem   [256];
  int        slave_delay [2];
  addr_t     exp_addr    [2];
  data_t     exp_wdata   [2];
  int        outstanding [2];
  logic [31:0] lfsr_q = 32'h5ba1;
  int        mismatch_cnt = 0;
  int        protocol_cnt = 0;

  always #(CLK_PERIOD / 2) clk_core = ~clk_core;

  core_bus_top #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) dut0 (
    .clk_core       (clk_core),
    .rst_n_i        (rst_n),
    .instr_req_i    (port_req[0]),
    .instr_rsp_o    (port_rsp[0]),
    .instr_wb_req_o (port_wb_req[0]),
    .instr_wb_rsp_i (port_wb_rsp[0]),
    .data_req_i     (port_req[1]),
    .data_rsp_o     (port_rsp[1]),
    .data_wb_req_o  (port_wb_req[1]),
    .data_wb_rsp_i  (port_wb_rsp[1])
  );

  bind bus_bridge bus_bridge_assertions u_bridge_assert (
    .clk_core   (clk_core),
    .rst_n_i    (rst_n_i),
    .core_rsp_i (core_rsp_o),
    .wb_req_i   (wb_req_o)
  );

  // Galois LFSR stepped once per random bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  function automatic data_t fill_word(input int i);
    logic [7:0] b;
    b = 8'(i);
    return {b, ~b, b ^ 8'h5a, b + 8'h3c};
  endfunction

  function automatic data_t merge_word(input data_t old, input data_t wd, input strb_t st);
    data_t v;
    v = old;
    for (int b = 0; b < STRB_W; b++) begin
      if (st[b]) v[8*b +: 8] = wd[8*b +: 8];
    end
    return v;
  endfunction

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  // Core side of one port and its reference model
  task automatic run_port(input int p);
    int gap;
    int d;
    int waited;
    logic we;
    strb_t strb;
    logic [7:0] idx;
    data_t wdata;
    data_t exp_rdata;
    for (int n = 0; n < TXN_PER_PORT; n++) begin
      gap = int'(rand_bits(2));
      repeat (gap) begin
        @(posedge clk_core);
        #1;
      end
      we    = 1'(rand_bits(1));
      strb  = strb_t'(rand_bits(STRB_W));
      idx   = {p[0], 3'b000, 4'(rand_bits(4))};  // Separate region per port
      wdata = rand_bits(32);
      d     = (rand_bits(3) == 32'd0) ? NEVER : int'(rand_bits(4) % 32'd14);
      slave_delay[p] = d;
      exp_addr[p]    = {22'h0, idx, 2'b00};
      exp_wdata[p]   = wdata;
      port_req[p] = '{req: 1'b1, we: we, strb: strb, addr: exp_addr[p], wdata: wdata};
      waited = 0;
      @(negedge clk_core);
      while (!port_rsp[p].gnt && waited < WAIT_LIMIT) begin
        @(negedge clk_core);
        waited++;
      end
      if (!port_rsp[p].gnt) begin
        $display("Port %0d never granted request %0d", p, n);
        protocol_cnt++;
      end
      @(posedge clk_core);
      #1;
      port_req[p].req = 1'b0;
      exp_rdata = (d == NEVER) ? '0 : model_mem[idx];
      if (we && d != NEVER) model_mem[idx] = merge_word(model_mem[idx], wdata, strb);
      waited = 0;
      @(negedge clk_core);
      while (!port_rsp[p].rvalid && waited < WAIT_LIMIT) begin
        @(negedge clk_core);
        waited++;
      end
      if (!port_rsp[p].rvalid) begin
        $display("Port %0d gave no response to request %0d", p, n);
        protocol_cnt++;
      end else begin
        check_err($sformatf("port%0d err", p), port_rsp[p].err, d == NEVER);
        if (!we || d == NEVER) check_data($sformatf("port%0d rdata", p), port_rsp[p].rdata,
                                          exp_rdata);
      end
      @(posedge clk_core);
      #1;
    end
  endtask

  // Wishbone slave of one port
  task automatic respond(input int p);
    int w;
    logic [7:0] idx;
    forever begin
      @(posedge clk_core);
      #1;
      if (rst_n && port_wb_req[p].cyc) begin
        idx = port_wb_req[p].addr[9:2];
        check_addr($sformatf("port%0d wb addr", p), port_wb_req[p].addr, exp_addr[p]);
        if (port_wb_req[p].we) check_data($sformatf("port%0d wb wdata", p),
                                          port_wb_req[p].wdata, exp_wdata[p]);
        w = 0;
        while (w < slave_delay[p] && port_wb_req[p].cyc) begin
          @(posedge clk_core);
          #1;
          w++;
        end
        if (slave_delay[p] != NEVER && port_wb_req[p].cyc) begin
          if (port_wb_req[p].we) begin
            slave_mem[idx] = merge_word(slave_mem[idx], port_wb_req[p].wdata,
                                        port_wb_req[p].strb);
            port_wb_rsp[p] = '{ack: 1'b1, rdata: '0};
          end else begin
            port_wb_rsp[p] = '{ack: 1'b1, rdata: slave_mem[idx]};
          end
          @(posedge clk_core);
          #1;
          port_wb_rsp[p] = '0;
        end
      end
    end
  endtask

  // One response per accept and quiet during reset
  always @(negedge clk_core) begin
    for (int p = 0; p < 2; p++) begin
      if (!rst_n) begin
        if (port_rsp[p].rvalid || port_wb_req[p].cyc) begin
          $display("Port %0d shows rvalid or cyc during reset", p);
          protocol_cnt++;
        end
        outstanding[p] = 0;
      end else begin
        if (port_rsp[p].rvalid) begin
          if (outstanding[p] != 1) begin
            $display("Port %0d gave rvalid without an accepted request", p);
            protocol_cnt++;
          end
          outstanding[p] = 0;
        end
        if (port_rsp[p].gnt && outstanding[p] != 0) begin
          $display("Port %0d granted before the previous rvalid", p);
          protocol_cnt++;
          outstanding[p] = 0;
        end
        if (port_req[p].req && port_rsp[p].gnt) begin
          outstanding[p] = 1;
        end
      end
    end
  end

  initial begin
    #(TXN_TOTAL * (TIMEOUT_CYCLES + 8) * CLK_PERIOD);
    $display("Watchdog expired before the tests completed");
    $display("Something failed");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    for (int p = 0; p < 2; p++) begin
      port_req[p]    = '0;
      port_wb_rsp[p] = '0;
      slave_delay[p] = 0;
      outstanding[p] = 0;
    end
    for (int i = 0; i < 256; i++) begin
      slave_mem[i] = fill_word(i);
      model_mem[i] = fill_word(i);
    end
    fork
      respond(0);
      respond(1);
    join_none
    repeat (4) @(posedge clk_core);
    #1;
    rst_n = 1'b1;
    fork
      run_port(0);
      run_port(1);
    join
    repeat (4) @(posedge clk_core);
    for (int i = 0; i < 256; i++) begin
      check_data($sformatf("slave_mem[%0d]", i), slave_mem[i], model_mem[i]);
    end
    $display("Errors: %0d mismatches, %0d protocol failures", mismatch_cnt, protocol_cnt);
    if (mismatch_cnt == 0 && protocol_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
common/bus_pkg.sv
common/ctrl_pkg.sv
hw/bridge/bridge_fsm.sv
hw/bridge/ack_timer.sv
hw/bridge/rsp_register.sv
hw/bridge/bus_bridge.sv
hw/core_bus_top.sv
bench/bus_bridge_assertions.sv
bench/tb_core_bus.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f compile.f --top-module tb_core_bus -o tb_core_bus
out=$(./obj_dir/tb_core_bus 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1
